//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module stack_cpu_tb \
  -f vlog.f -o stack_cpu_sim

./obj_dir/stack_cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
fi
exit 1

//--- verification/stack_cpu_model.svh
`ifndef STACK_CPU_MODEL_SVH
`define STACK_CPU_MODEL_SVH

// Instruction-level state of the core, stepped once per fetched instruction.
logic [`STK_WIDTH-1:0] m_ip, m_fp, m_stk0, m_stk1;
logic [`STK_WIDTH-1:0] m_ram [`DSTK_DEPTH];
logic [`STK_WIDTH-1:0] m_cstk [`CSTK_DEPTH];
logic [`STK_WIDTH-1:0] model_mem [256];
int                    m_dptr, m_cptr, m_steps;
stack_cpu_pkg::mem_req_t exp_q [$];  // Bus requests the core must issue next.

task automatic model_reset();
  m_ip = `RESET_IP;
  m_fp = '0;
  m_stk0 = '0;
  m_stk1 = '0;
  m_dptr = 0;
  m_cptr = 0;
  m_steps = 0;
  exp_q.delete();
endtask

task automatic expect_access(logic [15:0] addr, logic [15:0] wdata, logic we);
  exp_q.push_back('{addr: addr, wdata: wdata, we: we});
endtask

function automatic logic [15:0] cstk_top();
  return m_cstk[(m_cptr + `CSTK_DEPTH - 1) % `CSTK_DEPTH];
endfunction

function automatic logic [15:0] operand_a(logic [1:0] sel);
  case (sel)
    2'd1: return m_fp;
    2'd2: return m_ip;
    2'd3: return cstk_top();
    default: return m_stk0;
  endcase
endfunction

function automatic logic [15:0] alu_eval(logic [5:0] op, logic [15:0] a, logic [15:0] b);
  case (op)
    6'h01: return a + b;
    6'h02: return a - b;
    6'h03: return a & b;
    6'h04: return a | b;
    6'h05: return a ^ b;
    6'h06: return a << b[3:0];
    6'h07: return a >> b[3:0];
    6'h08: return (a == b) ? 16'd1 : 16'd0;
    6'h09: return (a < b) ? 16'd1 : 16'd0;
    6'h0f: return b;
    6'h20: return a + b;
    6'h30: return (m_stk0 == 16'd0) ? m_ip + b : m_ip;  // Branch target or next ip.
    6'h31: return (m_stk0 != 16'd0) ? m_ip + b : m_ip;
    default: return a;  // Unused codes pass A through.
  endcase
endfunction

// Push wins over pop, and a second-entry write lands last.
task automatic stack_update(logic push, logic pop, logic load, logic wr2, logic [15:0] value);
  logic [15:0] old0;
  old0 = m_stk0;
  if (push)
  begin
    m_ram[m_dptr] = m_stk1;
    m_stk1 = old0;
    m_stk0 = value;
    m_dptr = (m_dptr + 1) % `DSTK_DEPTH;
  end
  else if (pop)
  begin
    m_stk0 = load ? value : m_stk1;
    m_dptr = (m_dptr + `DSTK_DEPTH - 1) % `DSTK_DEPTH;
    m_stk1 = m_ram[m_dptr];
  end
  else if (load)
    m_stk0 = value;
  if (wr2)
    m_stk1 = old0;
endtask

task automatic cstk_push(logic [15:0] value);
  m_cstk[m_cptr] = value;
  m_cptr = (m_cptr + 1) % `CSTK_DEPTH;
endtask

task automatic model_step();
  logic [15:0] insn, a, b, val;
  logic [3:0]  lo;
  logic        take;
  insn = model_mem[m_ip[7:0]];
  expect_access(m_ip, '0, 1'b0);
  m_ip = m_ip + 16'd1;
  m_steps++;
  a = operand_a(insn[11:10]);
  lo = insn[3:0];
  if (insn[15])
    stack_update(1'b1, 1'b0, 1'b1, 1'b0, insn & 16'h7fff);  // Literal.
  else
  begin
    case (insn[14:12])
      3'd0:
      begin
        if (insn[0])
          cstk_push(m_ip);  // Call saves the return address.
        m_ip = m_ip + (insn & 16'h0ffe);
      end
      3'd1:
      begin
        take = insn[0] ? (m_stk0 != 0) : (m_stk0 == 0);
        if (take)
          m_ip = m_ip + (insn & 16'h0ffe);
        stack_update(1'b0, 1'b1, 1'b0, 1'b0, '0);
      end
      3'd2, 3'd3:
      begin
        b = insn & 16'h03fe;
        val = (insn[11:10] == 2'd0) ? b : a + b;
        if (insn[12])
        begin
          expect_access(val, m_stk0, 1'b1);
          model_mem[val[7:0]] = m_stk0;
          stack_update(1'b0, 1'b1, 1'b0, 1'b0, '0);
        end
        else
        begin
          expect_access(val, '0, 1'b0);
          stack_update(1'b1, 1'b0, 1'b1, 1'b0, model_mem[val[7:0]]);
        end
      end
      3'd4:
      begin
        b = insn & 16'h03ff;
        stack_update(1'b1, 1'b0, 1'b1, 1'b0, (insn[11:10] == 2'd0) ? b : a + b);
      end
      3'd5:
      begin
        b = insn & 16'h03ff;
        m_fp = (insn[11:10] == 2'd0) ? b : m_fp + b;
      end
      3'd7:
      begin
        if (!insn[11])
          stack_update(insn[7], insn[6], 1'b1, insn[3], alu_eval(insn[5:0], m_stk0, m_stk1));
        else
        begin
          a = (lo == 4'h0 || lo == 4'h2) ? cstk_top() : (lo == 4'h3) ? m_fp : m_stk0;
          val = a;
          if (lo[3:2] == 2'b10)
          begin
            expect_access(a, '0, 1'b0);
            val = model_mem[a[7:0]];
          end
          if (lo[3:2] == 2'b11)
          begin
            expect_access(a, m_stk1, 1'b1);
            model_mem[a[7:0]] = m_stk1;
          end
          if (lo == 4'h0 || lo == 4'h2)
            m_cptr = (m_cptr + `CSTK_DEPTH - 1) % `CSTK_DEPTH;
          if (lo == 4'h3)
            cstk_push(m_fp);
          if (lo == 4'h0)
            m_ip = a;  // Return.
          if (lo == 4'h2)
            m_fp = a;
          stack_update(insn[7], insn[2], insn[7] | (insn[3] & ~insn[1]), insn[3], val);
        end
      end
      default: ;
    endcase
  end
endtask

`endif

//--- verification/stack_cpu_tb.sv
`default_nettype none
`include "stack_cpu_settings.svh"

module stack_cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PROLOGUE = 24;   // Fills both stacks before random code runs.
  localparam int RUN_LEN = 200;
  localparam int NUM_TESTS = 6;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * ((PROLOGUE + RUN_LEN) * 20 + 4);

  logic                    clk;
  logic                    reset;
  logic                    mem_ack;
  logic [15:0]             mem_rdata;
  logic                    mem_req_valid, last_valid, running;
  stack_cpu_pkg::mem_req_t mem_req, last_req, exp;
  logic [15:0]             bus_mem [256];
  logic [31:0]             lcg_state;
  int                      ack_wait, errors, checks;

  `include "stack_cpu_model.svh"

  stack_cpu stack_cpu_inst (
    .clk(clk), .reset(reset), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
    .mem_ack(mem_ack), .mem_rdata(mem_rdata)
  );

  always #50 clk = ~clk;

  function logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  task automatic report_mismatch(string sig, logic [15:0] expv, logic [15:0] got);
    $display("mismatch at %0t: %s expected %h got %h", $time, sig, expv, got);
    errors++;
  endtask

  task automatic report_failure(string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endtask

  // ~~~~~~~~~~ Program generation ~~~~~~~~~~
  function automatic logic [15:0] gen_insn(int kind);
    logic [15:0] r;
    int          pick;
    r = next_rand();
    pick = next_rand() % 8;
    case (kind)
      2: case (pick % 4)
           0: return 16'h8000 | r;
           1: return 16'h7000 | r[10:0];
           2: return 16'h4000 | r[11:0];
           default: return 16'h3000 | r[11:0];
         endcase
      3: case (pick)
           0, 1: return 16'h8000 | r;
           2: return 16'h7000 | r[10:0];
           3: return 16'h0000 | r[11:0];   // Jump or call.
           4: return 16'h1000 | r[11:0];
           5: return 16'h7800;
           default: return 16'h3000 | r[11:0];
         endcase
      4: case (pick)
           0, 1: return 16'h8000 | r;
           2: return 16'h2000 | r[11:0];
           3: return 16'h3000 | r[11:0];
           4: return 16'h7808 | (r & 16'h0087);
           default: return 16'h7000 | r[10:0];
         endcase
      5: case (pick)
           0: return 16'h8000 | r;
           1: return 16'h5000 | r[11:0];
           2: return 16'h7803;
           3: return 16'h7802;
           4: return 16'h3400 | r[9:0];  // Store relative to fp.
           5: return 16'h2400 | r[9:0];
           default: return 16'h4000 | r[11:0];
         endcase
      default: return r;
    endcase
  endfunction

  task automatic load_program(int kind);
    logic [15:0] w;
    for (int i = 0; i < 256; i++)
    begin
      if (i < 16)
        w = 16'h8000 | (i * 16'h0123);
      else if (i < PROLOGUE)
        w = 16'h7803;
      else
        w = gen_insn(kind);
      bus_mem[i] = w;
      model_mem[i] = w;
    end
  endtask

  task automatic run_test(int num, int kind, string name);
    int start_errors;
    start_errors = errors;
    @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    load_program(kind);
    model_reset();
    reset <= 1'b0;
    checks++;
    assert (!mem_req_valid) else report_failure("mem_req_valid high during reset");
    running = 1'b1;
    while (!mem_req_valid)
      @(posedge clk);
    checks++;
    assert (mem_req.addr == `RESET_IP)
      else report_mismatch("mem_req.addr", `RESET_IP, mem_req.addr);
    assert (!mem_req.we) else report_mismatch("mem_req.we", 1'b0, mem_req.we);
    while (m_steps < PROLOGUE + RUN_LEN || exp_q.size() != 0)
      @(posedge clk);
    running = 1'b0;
    $display("test %0d %s: %0d errors", num, name, errors - start_errors);
  endtask

  // ~~~~~~~~~~ Bus responder ~~~~~~~~~~~~~~~
  always @(posedge clk)
  begin
    if (reset)
      mem_ack <= 1'b0;
    else if (mem_req_valid && !mem_ack)
    begin
      if (ack_wait == 0)
      begin
        mem_ack <= 1'b1;
        mem_rdata <= bus_mem[mem_req.addr[7:0]];
        if (mem_req.we)
          bus_mem[mem_req.addr[7:0]] <= mem_req.wdata;
        ack_wait <= next_rand() % 4;
      end
      else
        ack_wait <= ack_wait - 1;
    end
    else if (!mem_req_valid && mem_ack)
      mem_ack <= 1'b0;
  end

  // Compares each new request with the model and watches the handshake.
  always @(posedge clk)
  begin
    last_valid <= mem_req_valid;
    last_req <= mem_req;
    if (running && !reset)
    begin
      if (mem_req_valid && !last_valid)
      begin
        checks++;
        assert (!mem_ack) else report_failure("new request raised before mem_ack fell");
        if (exp_q.size() == 0)
          model_step();
        exp = exp_q.pop_front();
        assert (mem_req.addr == exp.addr) else report_mismatch("mem_req.addr", exp.addr, mem_req.addr);
        assert (mem_req.we == exp.we) else report_mismatch("mem_req.we", exp.we, mem_req.we);
        if (exp.we)
          assert (mem_req.wdata == exp.wdata)
            else report_mismatch("mem_req.wdata", exp.wdata, mem_req.wdata);
      end
      if (mem_req_valid && last_valid)
        assert (mem_req == last_req) else report_failure("mem_req changed while valid was high");
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the core stopped issuing the expected bus requests");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    clk = 1'b0;
    reset = 1'b1;
    mem_ack = 1'b0;
    mem_rdata = '0;
    running = 1'b0;
    last_valid = 1'b0;
    lcg_state = 32'd88910;
    ack_wait = 0;
    errors = 0;
    checks = 0;
    run_test(1, 2, "reset and first fetch");
    run_test(2, 2, "straight-line ALU and stores");
    run_test(3, 3, "control flow");
    run_test(4, 4, "loads and stores");
    run_test(5, 5, "frame pointer save and restore");
    run_test(6, 6, "handshake with random code");
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/call_stack.sv
`default_nettype none
`include "stack_cpu_settings.svh"

module call_stack (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  en,
  input  logic                  push,
  input  logic                  pop,
  input  logic [`STK_WIDTH-1:0] value,
  output logic [`STK_WIDTH-1:0] top
);

  localparam int PTR_W = $clog2(`CSTK_DEPTH);

  logic [`STK_WIDTH-1:0] regs [`CSTK_DEPTH];
  logic [PTR_W-1:0]      ptr;
  logic [PTR_W-1:0]      ptr_below;

  assign ptr_below = ptr - 1'b1;
  assign top       = regs[ptr_below];  // Latest entry.

  always_ff @(posedge clk)
  begin
    if (en && push)
      regs[pop ? ptr_below : ptr] <= value;  // Push with pop replaces the top.
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      ptr <= '0;
    else if (en && push && !pop)
      ptr <= ptr + 1'b1;
    else if (en && pop && !push)
      ptr <= ptr_below;
  end

endmodule

`default_nettype wire

//--- verilog/cpu_sequencer.sv
`default_nettype none
`include "stack_cpu_settings.svh"

module cpu_sequencer (
  input  logic                    clk,
  input  logic                    reset,
  input  stack_cpu_pkg::ctrl_t    ctrl,
  input  logic [`STK_WIDTH-1:0]   next_ip,
  input  logic [`STK_WIDTH-1:0]   next_fp,
  input  logic [`STK_WIDTH-1:0]   mem_addr,
  input  logic [`STK_WIDTH-1:0]   store_data,
  input  logic                    mem_ack,
  input  logic [`STK_WIDTH-1:0]   mem_rdata,
  output logic [15:0]             insn,
  output logic [`STK_WIDTH-1:0]   ip,
  output logic [`STK_WIDTH-1:0]   fp,
  output logic [`STK_WIDTH-1:0]   load_data,
  output logic                    dstk_en,
  output logic                    cstk_en,
  output stack_cpu_pkg::mem_req_t mem_req,
  output logic                    mem_req_valid
);

  stack_cpu_pkg::seq_state_e state;
  logic                      data_access;
  logic                      commit;

  // Jumps and calls are flagged as reads by the decoder but never go to the bus.
  assign data_access = (ctrl.rd_mem && !ctrl.load_ip) || ctrl.wr_mem;
  assign commit      = (state == stack_cpu_pkg::st_exec && !data_access) ||
                       (state == stack_cpu_pkg::st_mem_done && !mem_ack);
  assign dstk_en     = commit;
  assign cstk_en     = commit;

  // ~~~~~~~~~~ Request payload ~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (state == stack_cpu_pkg::st_fetch)
      mem_req <= '{addr: ip, wdata: '0, we: 1'b0};
    else if (state == stack_cpu_pkg::st_mem)
      mem_req <= '{addr: mem_addr, wdata: store_data, we: ctrl.wr_mem};
    if (state == stack_cpu_pkg::st_fetch_wait && mem_ack)
      insn <= mem_rdata;
    if (state == stack_cpu_pkg::st_mem_wait && mem_ack)
      load_data <= mem_rdata;
  end

  // ~~~~~~~~~~ FSM ~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state         <= stack_cpu_pkg::st_fetch;
      ip            <= `RESET_IP;
      fp            <= '0;
      mem_req_valid <= 1'b0;
    end
    else
    begin
      if (commit)
      begin
        ip <= next_ip;
        fp <= next_fp;
      end
      case (state)
        stack_cpu_pkg::st_fetch:
        begin
          mem_req_valid <= 1'b1;
          state         <= stack_cpu_pkg::st_fetch_wait;
        end
        stack_cpu_pkg::st_fetch_wait:
          if (mem_ack)
          begin
            mem_req_valid <= 1'b0;
            ip            <= ip + 1'b1;  // Execute sees the incremented ip.
            state         <= stack_cpu_pkg::st_fetch_done;
          end
        stack_cpu_pkg::st_fetch_done:
          if (!mem_ack)
            state <= stack_cpu_pkg::st_exec;
        stack_cpu_pkg::st_exec:
          state <= data_access ? stack_cpu_pkg::st_mem : stack_cpu_pkg::st_fetch;
        stack_cpu_pkg::st_mem:
        begin
          mem_req_valid <= 1'b1;
          state         <= stack_cpu_pkg::st_mem_wait;
        end
        stack_cpu_pkg::st_mem_wait:
          if (mem_ack)
          begin
            mem_req_valid <= 1'b0;
            state         <= stack_cpu_pkg::st_mem_done;
          end
        stack_cpu_pkg::st_mem_done:
          if (!mem_ack)
            state <= stack_cpu_pkg::st_fetch;
        default:
          state <= stack_cpu_pkg::st_fetch;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/data_stack.sv
`default_nettype none
`include "stack_cpu_settings.svh"

module data_stack (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     en,
  input  stack_cpu_pkg::stack_op_t op,
  input  logic [`STK_WIDTH-1:0]    value,
  output logic [`STK_WIDTH-1:0]    stk0,
  output logic [`STK_WIDTH-1:0]    stk1
);

  localparam int PTR_W = $clog2(`DSTK_DEPTH);

  logic [`STK_WIDTH-1:0] ram [`DSTK_DEPTH];
  logic [PTR_W-1:0]      ptr;        // Next free RAM slot.
  logic [PTR_W-1:0]      ptr_below;

  assign ptr_below = ptr - 1'b1;     // Wraps with the pointer.

  // The old second entry spills to RAM on every push.
  always_ff @(posedge clk)
  begin
    if (en && op.push)
      ram[ptr] <= stk1;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      stk0 <= '0;
      stk1 <= '0;
      ptr  <= '0;
    end
    else if (en)
    begin
      if (op.push)
      begin
        stk0 <= value;
        stk1 <= stk0;
        ptr  <= ptr + 1'b1;
      end
      else if (op.pop)
      begin
        stk0 <= op.load ? value : stk1;
        stk1 <= ram[ptr_below];
        ptr  <= ptr_below;
      end
      else if (op.load)
        stk0 <= value;
      if (op.wr_second)
        stk1 <= stk0;                // Wins over any refill above.
    end
  end

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`default_nettype none
`include "stack_cpu_settings.svh"

module exec_unit (
  input  stack_cpu_pkg::ctrl_t   ctrl,
  input  logic [15:0]            insn,
  input  logic [`STK_WIDTH-1:0]  stk0,
  input  logic [`STK_WIDTH-1:0]  stk1,
  input  logic [`STK_WIDTH-1:0]  cstk_top,
  input  logic [`STK_WIDTH-1:0]  ip,
  input  logic [`STK_WIDTH-1:0]  fp,
  input  logic [`STK_WIDTH-1:0]  load_data,
  output logic [`STK_WIDTH-1:0]  stack_value,
  output logic [`STK_WIDTH-1:0]  next_ip,
  output logic [`STK_WIDTH-1:0]  next_fp,
  output logic [`STK_WIDTH-1:0]  mem_addr,
  output logic [`STK_WIDTH-1:0]  store_data
);

  logic [`STK_WIDTH-1:0] a;
  logic [`STK_WIDTH-1:0] b;
  logic [`STK_WIDTH-1:0] result;

  // ~~~~~~~~~~ Operands ~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    case (ctrl.src_a)
      stack_cpu_pkg::src_fp:   a = fp;
      stack_cpu_pkg::src_ip:   a = ip;
      stack_cpu_pkg::src_cstk: a = cstk_top;
      default:                 a = stk0;
    endcase
  end

  assign b = ctrl.imm ? (insn & ctrl.imm_mask) : stk1;

  // ~~~~~~~~~~ ALU ~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    case (ctrl.alu_sel)
      stack_cpu_pkg::op_add:    result = a + b;
      stack_cpu_pkg::op_sub:    result = a - b;
      stack_cpu_pkg::op_and:    result = a & b;
      stack_cpu_pkg::op_or:     result = a | b;
      stack_cpu_pkg::op_xor:    result = a ^ b;
      stack_cpu_pkg::op_shl:    result = a << b[3:0];
      stack_cpu_pkg::op_shr:    result = a >> b[3:0];
      stack_cpu_pkg::op_eq:     result = {{(`STK_WIDTH-1){1'b0}}, a == b};
      stack_cpu_pkg::op_lt:     result = {{(`STK_WIDTH-1){1'b0}}, a < b};
      stack_cpu_pkg::op_pass_b: result = b;
      stack_cpu_pkg::op_addr:   result = a + b;
      stack_cpu_pkg::op_bz:     result = (stk0 == '0) ? ip + b : ip;
      stack_cpu_pkg::op_bnz:    result = (stk0 != '0) ? ip + b : ip;
      default:                  result = a;
    endcase
  end

  // A data load returns its word to the stack; a branch never does.
  assign stack_value = (ctrl.rd_mem && !ctrl.load_ip) ? load_data : result;
  assign next_ip     = ctrl.load_ip ? result : ip;
  assign next_fp     = ctrl.load_fp ? result : fp;
  assign mem_addr    = result;
  assign store_data  = (insn[15:12] == 4'h3) ? stk0 : stk1;

endmodule

`default_nettype wire

//--- verilog/insn_decoder.sv
`default_nettype none

module insn_decoder (
  input  logic [15:0]         insn,
  output stack_cpu_pkg::ctrl_t ctrl
);

  always_comb
  begin
    ctrl.imm      = insn[15:12] != 4'h7;  // Every group but 0111 carries an immediate.
    ctrl.imm_mask = calc_imm_mask(insn[15:12]);
    ctrl.src_a    = calc_src_a(insn);
    ctrl.alu_sel  = calc_alu_sel(insn);
    ctrl.wr_stk1  = ~ctrl.imm & insn[3];
    ctrl.pop      = calc_pop(insn);
    ctrl.push     = calc_push(insn);
    ctrl.load_stk = calc_load_stk(insn);
    ctrl.load_fp  = calc_load_fp(insn);
    ctrl.load_ip  = calc_load_ip(insn);
    ctrl.cpop     = calc_cpop(insn);
    ctrl.cpush    = calc_cpush(insn);
    ctrl.byt      = insn[0];
    ctrl.rd_mem   = calc_rd_mem(insn);
    ctrl.wr_mem   = calc_wr_mem(insn);
  end

  // ~~~~~~~~~~ Field decode ~~~~~~~~~~~~~~~~
  function automatic logic [15:0] calc_imm_mask(input logic [3:0] op);
    casez (op)
      4'b1???: calc_imm_mask = 16'h7fff;
      4'b000?: calc_imm_mask = 16'h0ffe;  // Branch offsets stay even.
      4'b001?: calc_imm_mask = 16'h03fe;
      default: calc_imm_mask = 16'h03ff;
    endcase
  endfunction

  function automatic stack_cpu_pkg::src_e calc_src_a(input logic [15:0] ins);
    casez (ins)
      16'b000?_????_????_????: calc_src_a = stack_cpu_pkg::src_ip;
      16'b001?_????_????_????: calc_src_a = stack_cpu_pkg::src_e'(ins[11:10]);
      16'b0100_????_????_????: calc_src_a = stack_cpu_pkg::src_e'(ins[11:10]);
      16'b0101_????_????_????: calc_src_a = stack_cpu_pkg::src_fp;
      16'b0111_1???_????_00?0: calc_src_a = stack_cpu_pkg::src_cstk;
      16'b0111_1???_????_0011: calc_src_a = stack_cpu_pkg::src_fp;
      default:                 calc_src_a = stack_cpu_pkg::src_stk0;
    endcase
  endfunction

  function automatic stack_cpu_pkg::alu_op_e calc_alu_sel(input logic [15:0] ins);
    casez (ins)
      16'b1???_????_????_????: calc_alu_sel = stack_cpu_pkg::op_pass_b;
      16'b0000_????_????_????: calc_alu_sel = stack_cpu_pkg::op_addr;
      16'b0001_????_????_???0: calc_alu_sel = stack_cpu_pkg::op_bz;
      16'b0001_????_????_???1: calc_alu_sel = stack_cpu_pkg::op_bnz;
      16'b001?_00??_????_????: calc_alu_sel = stack_cpu_pkg::op_pass_b;  // Absolute address.
      16'b001?_????_????_????: calc_alu_sel = stack_cpu_pkg::op_addr;
      16'b010?_00??_????_????: calc_alu_sel = stack_cpu_pkg::op_pass_b;
      16'b010?_????_????_????: calc_alu_sel = stack_cpu_pkg::op_addr;
      16'b0111_0???_????_????: calc_alu_sel = stack_cpu_pkg::alu_op_e'(ins[5:0]);
      default:                 calc_alu_sel = stack_cpu_pkg::op_pass_a;
    endcase
  endfunction

  // ~~~~~~~~~~ Stack and memory strobes ~~~~
  function automatic logic calc_rd_mem(input logic [15:0] ins);
    casez (ins)
      16'b00??_????_????_????: calc_rd_mem = 1'b1;
      16'b0111_1???_????_10??: calc_rd_mem = 1'b1;
      default:                 calc_rd_mem = 1'b0;
    endcase
  endfunction

  function automatic logic calc_pop(input logic [15:0] ins);
    casez (ins)
      16'b00?1_????_????_????: calc_pop = 1'b1;
      16'b0111_0???_?1??_????: calc_pop = 1'b1;
      16'b0111_1???_????_?1??: calc_pop = 1'b1;
      default:                 calc_pop = 1'b0;
    endcase
  endfunction

  function automatic logic calc_push(input logic [15:0] ins);
    casez (ins)
      16'b1???_????_????_????: calc_push = 1'b1;
      16'b0010_????_????_????: calc_push = 1'b1;
      16'b0100_????_????_????: calc_push = 1'b1;
      16'b0111_????_1???_????: calc_push = 1'b1;
      default:                 calc_push = 1'b0;
    endcase
  endfunction

  function automatic logic calc_load_stk(input logic [15:0] ins);
    casez (ins)
      16'b0111_0???_????_????: calc_load_stk = 1'b1;
      16'b0111_1???_????_1?0?: calc_load_stk = 1'b1;
      default:                 calc_load_stk = calc_push(ins);
    endcase
  endfunction

  function automatic logic calc_load_fp(input logic [15:0] ins);
    casez (ins)
      16'b0101_????_????_????: calc_load_fp = 1'b1;
      16'b0111_1???_????_0010: calc_load_fp = 1'b1;
      default:                 calc_load_fp = 1'b0;
    endcase
  endfunction

  function automatic logic calc_load_ip(input logic [15:0] ins);
    casez (ins)
      16'b000?_????_????_????: calc_load_ip = 1'b1;
      16'b0111_1???_????_0000: calc_load_ip = 1'b1;
      default:                 calc_load_ip = 1'b0;
    endcase
  endfunction

  function automatic logic calc_cpop(input logic [15:0] ins);
    casez (ins)
      16'b0111_1???_????_00?0: calc_cpop = 1'b1;  // Return and frame restore.
      default:                 calc_cpop = 1'b0;
    endcase
  endfunction

  function automatic logic calc_cpush(input logic [15:0] ins);
    casez (ins)
      16'b0000_????_????_???1: calc_cpush = 1'b1;
      16'b0111_1???_????_0011: calc_cpush = 1'b1;
      default:                 calc_cpush = 1'b0;
    endcase
  endfunction

  function automatic logic calc_wr_mem(input logic [15:0] ins);
    casez (ins)
      16'b0011_????_????_????: calc_wr_mem = 1'b1;
      16'b0111_1???_????_11??: calc_wr_mem = 1'b1;
      default:                 calc_wr_mem = 1'b0;
    endcase
  endfunction

endmodule

`default_nettype wire

//--- verilog/stack_cpu.sv
`default_nettype none
`include "stack_cpu_settings.svh"

module stack_cpu (
  input  logic                    clk,
  input  logic                    reset,
  output stack_cpu_pkg::mem_req_t mem_req,
  output logic                    mem_req_valid,
  input  logic                    mem_ack,
  input  logic [`STK_WIDTH-1:0]   mem_rdata
);

  stack_cpu_pkg::ctrl_t     ctrl;
  stack_cpu_pkg::stack_op_t dstk_op;
  logic [15:0]              insn;
  logic [`STK_WIDTH-1:0]    ip, fp, stk0, stk1, cstk_top, cstk_value, load_data;
  logic [`STK_WIDTH-1:0]    stack_value, next_ip, next_fp, mem_addr, store_data;
  logic                     dstk_en, cstk_en;

  assign dstk_op    = '{push: ctrl.push, pop: ctrl.pop, load: ctrl.load_stk,
                        wr_second: ctrl.wr_stk1};
  assign cstk_value = ctrl.load_ip ? ip : fp;  // Return address on a call, else fp.

  insn_decoder insn_decoder_inst (.insn(insn), .ctrl(ctrl));

  data_stack data_stack_inst (
    .clk(clk), .reset(reset), .en(dstk_en), .op(dstk_op), .value(stack_value),
    .stk0(stk0), .stk1(stk1)
  );

  call_stack call_stack_inst (
    .clk(clk), .reset(reset), .en(cstk_en), .push(ctrl.cpush), .pop(ctrl.cpop),
    .value(cstk_value), .top(cstk_top)
  );

  exec_unit exec_unit_inst (
    .ctrl(ctrl), .insn(insn), .stk0(stk0), .stk1(stk1), .cstk_top(cstk_top),
    .ip(ip), .fp(fp), .load_data(load_data), .stack_value(stack_value),
    .next_ip(next_ip), .next_fp(next_fp), .mem_addr(mem_addr), .store_data(store_data)
  );

  cpu_sequencer cpu_sequencer_inst (
    .clk(clk), .reset(reset), .ctrl(ctrl), .next_ip(next_ip), .next_fp(next_fp),
    .mem_addr(mem_addr), .store_data(store_data), .mem_ack(mem_ack),
    .mem_rdata(mem_rdata), .insn(insn), .ip(ip), .fp(fp), .load_data(load_data),
    .dstk_en(dstk_en), .cstk_en(cstk_en), .mem_req(mem_req),
    .mem_req_valid(mem_req_valid)
  );

endmodule

`default_nettype wire

//--- verilog/stack_cpu_pkg.sv
`default_nettype none
`include "stack_cpu_settings.svh"

package stack_cpu_pkg;

  typedef enum logic [5:0] {
    op_pass_a = 6'h00,
    op_add    = 6'h01,
    op_sub    = 6'h02,
    op_and    = 6'h03,
    op_or     = 6'h04,
    op_xor    = 6'h05,
    op_shl    = 6'h06,  // A shifted left by B[3:0].
    op_shr    = 6'h07,
    op_eq     = 6'h08,
    op_lt     = 6'h09,  // Unsigned compare.
    op_pass_b = 6'h0f,
    op_addr   = 6'h20,
    op_bz     = 6'h30,
    op_bnz    = 6'h31
  } alu_op_e;

  typedef enum logic [1:0] {
    src_stk0 = 2'h0,
    src_fp   = 2'h1,
    src_ip   = 2'h2,
    src_cstk = 2'h3
  } src_e;

  // Decoder outputs, one bundle per instruction.
  typedef struct packed {
    logic        imm;
    logic [15:0] imm_mask;
    src_e        src_a;
    alu_op_e     alu_sel;
    logic        wr_stk1;
    logic        pop;
    logic        push;
    logic        load_stk;
    logic        load_fp;
    logic        load_ip;
    logic        cpop;
    logic        cpush;
    logic        byt;
    logic        rd_mem;
    logic        wr_mem;
  } ctrl_t;

  typedef struct packed {
    logic [`STK_WIDTH-1:0] addr;
    logic [`STK_WIDTH-1:0] wdata;
    logic                  we;
  } mem_req_t;

  typedef enum logic [2:0] {
    st_fetch,
    st_fetch_wait,
    st_fetch_done,
    st_exec,
    st_mem,
    st_mem_wait,
    st_mem_done
  } seq_state_e;

  typedef struct packed {
    logic push;
    logic pop;
    logic load;
    logic wr_second;
  } stack_op_t;

endpackage

`default_nettype wire

//--- verilog/stack_cpu_settings.svh
`ifndef STACK_CPU_SETTINGS_SVH
`define STACK_CPU_SETTINGS_SVH

// Data path word width.
`define STK_WIDTH 16

// Entries in the data stack RAM below the two top registers.
`define DSTK_DEPTH 16

// Entries in the call stack.
`define CSTK_DEPTH 8

`define RESET_IP 16'h0000  // First fetch address after reset.

`endif

//--- vlog.f
+incdir+verilog
+incdir+verification
verilog/stack_cpu_pkg.sv
verilog/insn_decoder.sv
verilog/data_stack.sv
verilog/call_stack.sv
verilog/exec_unit.sv
verilog/cpu_sequencer.sv
verilog/stack_cpu.sv
verification/stack_cpu_tb.sv
